/* vlog.f */
+incdir+src
src/oramTestPkg.sv
src/widthFunnel.sv
src/blockController.sv
src/trafficGen.sv
src/dummyResponder.sv
src/oramTestWrap.sv
bench/tbDramModel.sv
bench/oramTestTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= oramTestTb
RTL_TOP ?= oramTestWrap
FILELIST ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) $(LINT_FLAGS) +incdir+src src/oramTestPkg.sv src/widthFunnel.sv \
		src/blockController.sv src/trafficGen.sv src/dummyResponder.sv \
		src/oramTestWrap.sv --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)

/* bench/oramTestTb.sv */
// Testbench for oramTestWrap running user, traffic and dummy modes in turn
// User blocks use addresses 0 to 7 only
// Inputs driven 1 ns after the rising edge
`timescale 1ns/1ps
`default_nettype none

module oramTestTb;
	localparam int UserOps = 60;
	localparam int TrafficAccesses = 20;
	// Roughly 80 cycles per stalled user op, 40 per traffic access, plus dummy and resets
	localparam int MaxCycles = UserOps * 80 + TrafficAccesses * 2 * 40 + 2000;

	logic Clock = 1'b0;
	logic rstN;
	oramTestPkg::frontCmd_t CmdIn;
	logic CmdValid, CmdReady;
	oramTestPkg::beatData_t DataIn, DataOut;
	logic DataInValid, DataInReady, DataOutValid, DataOutReady;
	oramTestPkg::dramCmd_t DramCmd;
	logic DramCmdValid, DramCmdReady;
	oramTestPkg::netData_t DramReadData, DramWriteData;
	logic DramReadDataValid, DramWriteDataValid, DramWriteDataReady;
	logic TrafficMode, DummyMode, DebugReq;
	oramTestPkg::debugByte_t DebugData;
	logic CmdStall, WriteStall, WriteDone;
	int ReadCount;
	oramTestPkg::blockAddr_t WriteAddr;
	oramTestPkg::netData_t WriteWord0, WriteWord1;

	// Reference model and expected DRAM writes
	oramTestPkg::beatData_t refMem [8][4];
	oramTestPkg::netData_t expWords [$];
	oramTestPkg::blockAddr_t expAddr [$];
	logic [31:0] rngState = 32'd14;
	logic [31:0] stallState = 32'd14;
	int cycleCount = 0;
	logic userPhase = 1'b0;
	logic trafficPhase = 1'b0;
	logic dummyPhase = 1'b0;
	logic readActive = 1'b0;

	always #2 Clock = ~Clock;

	oramTestWrap UUT (
		.Clock(Clock), .rstN(rstN),
		.CmdIn(CmdIn), .CmdValid(CmdValid), .CmdReady(CmdReady),
		.DataIn(DataIn), .DataInValid(DataInValid), .DataInReady(DataInReady),
		.DataOut(DataOut), .DataOutValid(DataOutValid), .DataOutReady(DataOutReady),
		.DramCmd(DramCmd), .DramCmdValid(DramCmdValid), .DramCmdReady(DramCmdReady),
		.DramReadData(DramReadData), .DramReadDataValid(DramReadDataValid),
		.DramWriteData(DramWriteData), .DramWriteDataValid(DramWriteDataValid),
		.DramWriteDataReady(DramWriteDataReady),
		.TrafficMode(TrafficMode), .DummyMode(DummyMode),
		.DebugReq(DebugReq), .DebugData(DebugData)
	);

	tbDramModel dram (
		.Clock(Clock), .rstN(rstN),
		.Cmd(DramCmd), .CmdValid(DramCmdValid), .CmdReady(DramCmdReady),
		.ReadData(DramReadData), .ReadDataValid(DramReadDataValid),
		.WriteData(DramWriteData), .WriteDataValid(DramWriteDataValid),
		.WriteDataReady(DramWriteDataReady),
		.CmdStall(CmdStall), .WriteStall(WriteStall),
		.ReadCount(ReadCount), .WriteDone(WriteDone), .WriteAddr(WriteAddr),
		.WriteWord0(WriteWord0), .WriteWord1(WriteWord1)
	);

	// --------------------------------------------------
	// Helpers
	// --------------------------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] nextRand();
		rngState = xorshift32(rngState);
		return rngState;
	endfunction

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic checkBeat(input string name, input oramTestPkg::beatData_t got,
		input oramTestPkg::beatData_t exp);
		if (got !== exp)
			failRun($sformatf("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic checkNet(input string name, input oramTestPkg::netData_t got,
		input oramTestPkg::netData_t exp);
		if (got !== exp)
			failRun($sformatf("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic checkByte(input string name, input oramTestPkg::debugByte_t got,
		input oramTestPkg::debugByte_t exp);
		if (got !== exp)
			failRun($sformatf("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic checkAddr(input string name, input oramTestPkg::blockAddr_t got,
		input oramTestPkg::blockAddr_t exp);
		if (got !== exp)
			failRun($sformatf("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp));
	endtask

	// DRAM ready stalls drawn from a second xorshift stream
	always @(posedge Clock) begin
		#1;
		stallState = xorshift32(stallState);
		CmdStall = stallState[0] & stallState[1];
		WriteStall = stallState[2] & stallState[3];
	end

	always @(posedge Clock) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= MaxCycles)
			failRun("Timeout, the run did not finish within the cycle limit");
	end

	// --------------------------------------------------
	// Monitors
	// --------------------------------------------------
	always @(posedge Clock) begin
		if (userPhase && DataOutValid && !readActive)
			failRun("DataOutValid high with no read outstanding");
		if (trafficPhase && (CmdReady || DataInReady || DataOutValid))
			failRun("User port handshake active in traffic mode");
		if (dummyPhase && (DramCmdValid || DramWriteDataValid || DataOutValid))
			failRun("DRAM or user valid active in dummy mode");
	end

	// Each DRAM write must carry the merged block with beat 0 in the low half
	always @(posedge Clock) begin
		if (WriteDone && userPhase) begin
			if (expWords.size() < 2) begin
				failRun("DRAM write seen with no expected block");
			end else begin
				checkNet("DramWriteData word 0", WriteWord0, expWords.pop_front());
				checkNet("DramWriteData word 1", WriteWord1, expWords.pop_front());
				checkAddr("DramCmd.addr", WriteAddr, expAddr.pop_front());
			end
		end
	end

	// --------------------------------------------------
	// Tasks
	// --------------------------------------------------
	task automatic resetDut();
		rstN = 1'b0;
		CmdValid = 1'b0;
		DataInValid = 1'b0;
		DataOutReady = 1'b0;
		DebugReq = 1'b0;
		repeat (10) @(posedge Clock);
		if (DataOutValid || DramCmdValid || DramWriteDataValid)
			failRun("A valid output is high during reset");
		checkByte("DebugData", DebugData, '0);
		#1 rstN = 1'b1;
	endtask

	// Called 1 ns after an edge and gives the status word MSB first
	task automatic readStatus(output logic [31:0] word);
		word = '0;
		DebugReq = 1'b1;
		@(posedge Clock);
		#1 DebugReq = 1'b0;
		for (int i = 0; i < 4; i++) begin
			word = {word[23:0], DebugData};
			DebugReq = 1'b1;
			@(posedge Clock);
			#1 DebugReq = 1'b0;
		end
		checkByte("DebugData", DebugData, '0);
	endtask

	task automatic runUserMode();
		oramTestPkg::frontCmd_t cmd;
		oramTestPkg::beatData_t beat;
		oramTestPkg::beatData_t blk [4];
		logic [31:0] r;
		int b;
		for (int n = 0; n < UserOps; n++) begin
			r = nextRand();
			cmd.op = r[0] ? oramTestPkg::FrontWrite : oramTestPkg::FrontRead;
			cmd.addr = oramTestPkg::blockAddr_t'(r[3:1]);
			cmd.mask = r[7:4];
			CmdIn = cmd;
			CmdValid = 1'b1;
			@(posedge Clock);
			while (!CmdReady)
				@(posedge Clock);
			#1 CmdValid = 1'b0;
			if (cmd.op == oramTestPkg::FrontWrite) begin
				for (b = 0; b < 4; b++) begin
					beat = nextRand();
					blk[b] = cmd.mask[b] ? beat : refMem[cmd.addr[2:0]][b];
					DataIn = beat;
					DataInValid = 1'b1;
					@(posedge Clock);
					while (!DataInReady)
						@(posedge Clock);
					#1 DataInValid = 1'b0;
				end
				for (b = 0; b < 4; b++)
					refMem[cmd.addr[2:0]][b] = blk[b];
				expWords.push_back({blk[1], blk[0]});
				expWords.push_back({blk[3], blk[2]});
				expAddr.push_back(cmd.addr);
			end else begin
				readActive = 1'b1;
				r = nextRand();
				DataOutReady = r[0];
				b = 0;
				while (b < 4) begin
					@(posedge Clock);
					if (DataOutValid && DataOutReady) begin
						checkBeat($sformatf("DataOut beat %0d", b), DataOut,
							refMem[cmd.addr[2:0]][b]);
						b++;
					end
					#1;
					if (b < 4) begin
						r = nextRand();
						DataOutReady = r[0];
					end else begin
						DataOutReady = 1'b0;
					end
				end
				readActive = 1'b0;
			end
		end
		// Last write-back may still sit in the write funnel
		while (expWords.size() != 0)
			@(posedge Clock);
		#1;
	endtask

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------
	initial begin
		logic [31:0] status;
		logic [31:0] later;
		logic [31:0] expStatus;
		rstN = 1'b0;
		CmdIn = '0;
		CmdValid = 1'b0;
		DataIn = '0;
		DataInValid = 1'b0;
		DataOutReady = 1'b0;
		TrafficMode = 1'b0;
		DummyMode = 1'b0;
		DebugReq = 1'b0;
		CmdStall = 1'b0;
		WriteStall = 1'b0;
		for (int a = 0; a < 8; a++)
			for (int b = 0; b < 4; b++)
				refMem[a][b] = '0;

		resetDut();
		userPhase = 1'b1;
		runUserMode();
		userPhase = 1'b0;

		// Access k+1 reads DRAM only after access k is done
		TrafficMode = 1'b1;
		resetDut();
		trafficPhase = 1'b1;
		do begin
			@(posedge Clock);
			#1;
		end while (ReadCount < TrafficAccesses + 1);
		readStatus(status);
		expStatus = {16'(ReadCount - 1), 16'h0000};
		for (int i = 3; i >= 0; i--)
			checkByte($sformatf("status byte %0d", i), status[i*8 +: 8], expStatus[i*8 +: 8]);
		trafficPhase = 1'b0;

		TrafficMode = 1'b0;
		DummyMode = 1'b1;
		resetDut();
		dummyPhase = 1'b1;
		repeat (50) @(posedge Clock);
		#1;
		readStatus(status);
		repeat (200) @(posedge Clock);
		#1;
		readStatus(later);
		if (later[31:16] <= status[31:16])
			failRun("Dummy mode access count did not increase");
		dummyPhase = 1'b0;

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

/* bench/tbDramModel.sv */
// Behavioural 64-bit DRAM for the testbench, 256 blocks of two words, starts at zero
// Reads return word 0 three cycles after the command, word 1 two cycles later
// No new command is taken while a read or the words of a write are pending
`timescale 1ns/1ps
`default_nettype none

module tbDramModel (
	input wire logic Clock,
	input wire logic rstN,
	input wire oramTestPkg::dramCmd_t Cmd,
	input wire logic CmdValid,
	output logic CmdReady,
	output oramTestPkg::netData_t ReadData,
	output logic ReadDataValid,
	input wire oramTestPkg::netData_t WriteData,
	input wire logic WriteDataValid,
	output logic WriteDataReady,
	input wire logic CmdStall,
	input wire logic WriteStall,
	output int ReadCount,
	output logic WriteDone,
	output oramTestPkg::blockAddr_t WriteAddr,
	output oramTestPkg::netData_t WriteWord0,
	output oramTestPkg::netData_t WriteWord1
);
	oramTestPkg::netData_t mem [256][2];
	oramTestPkg::blockAddr_t readAddr;
	// 0 idle, 1 to 3 latency, 4 word 0, 5 gap for the read funnel, 6 word 1
	logic [2:0] phase;
	logic [1:0] writeLeft;

	initial begin
		for (int a = 0; a < 256; a++) begin
			mem[a][0] = '0;
			mem[a][1] = '0;
		end
	end

	assign CmdReady = (phase == 3'd0) && (writeLeft == 2'd0) && !CmdStall;
	assign ReadDataValid = (phase == 3'd4) || (phase == 3'd6);
	assign ReadData = mem[readAddr[7:0]][phase == 3'd6];
	assign WriteDataReady = (writeLeft != 2'd0) && !WriteStall;

	always @(posedge Clock) begin
		if (WriteDataValid && WriteDataReady)
			mem[WriteAddr[7:0]][writeLeft == 2'd1] <= WriteData;
	end

	always @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			phase <= 3'd0;
			writeLeft <= 2'd0;
			readAddr <= '0;
			ReadCount <= 0;
			WriteDone <= 1'b0;
			WriteAddr <= '0;
			WriteWord0 <= '0;
			WriteWord1 <= '0;
		end else begin
			WriteDone <= 1'b0;
			if (CmdValid && CmdReady) begin
				if (Cmd.op == oramTestPkg::DramRead) begin
					phase <= 3'd1;
					readAddr <= Cmd.addr;
					ReadCount <= ReadCount + 1;
				end else begin
					writeLeft <= 2'd2;
					WriteAddr <= Cmd.addr;
				end
			end else if (phase != 3'd0) begin
				phase <= (phase == 3'd6) ? 3'd0 : phase + 3'd1;
			end
			// Word 0 first, pulse once the block is complete
			if (WriteDataValid && WriteDataReady) begin
				if (writeLeft == 2'd2) begin
					WriteWord0 <= WriteData;
				end else begin
					WriteWord1 <= WriteData;
					WriteDone <= 1'b1;
				end
				writeLeft <= writeLeft - 2'd1;
			end
		end
	end

endmodule

`default_nettype wire

/* src/oramTestWrap.sv */
// Test-chip wrapper, user or traffic-gen front end, real or dummy DRAM backend
// DummyMode overrides TrafficMode and keeps the DRAM and user ports silent
// Debug word is {access count, traffic mismatch count}, MSB first
`timescale 1ns/1ps
`default_nettype none
`include "oramTest_defs.svh"

module oramTestWrap (
	input wire logic Clock,
	input wire logic rstN,
	input wire oramTestPkg::frontCmd_t CmdIn,
	input wire logic CmdValid,
	output logic CmdReady,
	input wire oramTestPkg::beatData_t DataIn,
	input wire logic DataInValid,
	output logic DataInReady,
	output oramTestPkg::beatData_t DataOut,
	output logic DataOutValid,
	input wire logic DataOutReady,
	output oramTestPkg::dramCmd_t DramCmd,
	output logic DramCmdValid,
	input wire logic DramCmdReady,
	input wire oramTestPkg::netData_t DramReadData,
	input wire logic DramReadDataValid,
	output oramTestPkg::netData_t DramWriteData,
	output logic DramWriteDataValid,
	input wire logic DramWriteDataReady,
	input wire logic TrafficMode,
	input wire logic DummyMode,
	input wire logic DebugReq,
	output oramTestPkg::debugByte_t DebugData
);
	oramTestPkg::frontCmd_t ctrlCmd, genCmd;
	oramTestPkg::beatData_t ctrlDataIn, ctrlDataOut, genDataIn;
	oramTestPkg::dramCmd_t ctrlDramCmd;
	oramTestPkg::beatData_t beatIn, beatOut, readBeat, respBeat;
	logic ctrlCmdValid, ctrlCmdReady, ctrlDataInValid, ctrlDataInReady;
	logic ctrlDataOutValid, ctrlDataOutReady, ctrlDramCmdValid, ctrlDramCmdReady;
	logic genCmdValid, genCmdReady, genDataInValid, genDataInReady;
	logic genDataOutValid, genDataOutReady;
	logic beatInValid, beatOutValid, beatOutReady, readBeatValid, writeAccept;
	logic respCmdValid, respCmdReady, respBeatValid, accessDone;
	logic [`ORAM_STATUS_WIDTH/2-1:0] accessCount, errorCount;
	logic [`ORAM_STATUS_WIDTH-1:0] statusWord;
	logic debugFull;

	// --------------------------------------------------
	// Front-end muxing
	// --------------------------------------------------
	always_comb begin
		ctrlCmd = CmdIn;
		if (TrafficMode) begin
			ctrlCmd = genCmd;
			ctrlCmd.mask = '1;
		end
	end
	assign ctrlCmdValid = (TrafficMode ? genCmdValid : CmdValid) && !DummyMode;
	assign genCmdReady = TrafficMode && ctrlCmdReady;
	assign CmdReady = !TrafficMode && ctrlCmdReady;

	assign ctrlDataIn = TrafficMode ? genDataIn : DataIn;
	assign ctrlDataInValid = (TrafficMode ? genDataInValid : DataInValid) && !DummyMode;
	assign genDataInReady = TrafficMode && ctrlDataInReady;
	assign DataInReady = !TrafficMode && ctrlDataInReady;

	assign DataOut = ctrlDataOut;
	assign DataOutValid = !TrafficMode && ctrlDataOutValid;
	assign genDataOutValid = TrafficMode && ctrlDataOutValid;
	assign ctrlDataOutReady = TrafficMode ? genDataOutReady : DataOutReady;

	trafficGen tgen (
		.Clock(Clock), .rstN(rstN),
		.Cmd(genCmd), .CmdValid(genCmdValid), .CmdReady(genCmdReady),
		.DataIn(genDataIn), .DataInValid(genDataInValid), .DataInReady(genDataInReady),
		.DataOut(ctrlDataOut), .DataOutValid(genDataOutValid),
		.DataOutReady(genDataOutReady), .ErrorCount(errorCount)
	);

	blockController ctrl (
		.Clock(Clock), .rstN(rstN), .DummyMode(DummyMode),
		.Cmd(ctrlCmd), .CmdValid(ctrlCmdValid), .CmdReady(ctrlCmdReady),
		.DataIn(ctrlDataIn), .DataInValid(ctrlDataInValid), .DataInReady(ctrlDataInReady),
		.DataOut(ctrlDataOut), .DataOutValid(ctrlDataOutValid),
		.DataOutReady(ctrlDataOutReady),
		.DramCmd(ctrlDramCmd), .DramCmdValid(ctrlDramCmdValid),
		.DramCmdReady(ctrlDramCmdReady),
		.BeatIn(beatIn), .BeatInValid(beatInValid),
		.BeatOut(beatOut), .BeatOutValid(beatOutValid), .BeatOutReady(beatOutReady),
		.AccessDone(accessDone)
	);

	// --------------------------------------------------
	// Backend muxing, dummy responder takes reads only
	// --------------------------------------------------
	assign DramCmd = ctrlDramCmd;
	assign DramCmdValid = ctrlDramCmdValid && !DummyMode;
	assign respCmdValid = DummyMode && ctrlDramCmdValid &&
		(ctrlDramCmd.op == oramTestPkg::DramRead);
	// Dummy write commands and beats are swallowed
	assign ctrlDramCmdReady = DummyMode ?
		((ctrlDramCmd.op == oramTestPkg::DramRead) ? respCmdReady : 1'b1) : DramCmdReady;
	assign beatIn = DummyMode ? respBeat : readBeat;
	assign beatInValid = DummyMode ? respBeatValid : readBeatValid;
	assign beatOutReady = DummyMode ? 1'b1 : writeAccept;

	dummyResponder dgen (
		.Clock(Clock), .rstN(rstN),
		.CmdValid(respCmdValid), .CmdReady(respCmdReady),
		.BeatOut(respBeat), .BeatOutValid(respBeatValid)
	);

	// 64-bit word to two beats, low half first, never stalled
	widthFunnel #(.InWidth(`ORAM_NET_WIDTH), .OutWidth(`ORAM_BED_WIDTH), .Registered(1'b1))
		readFunnel (
		.Clock(Clock), .rstN(rstN),
		.InData(DramReadData), .InValid(DramReadDataValid), .InAccept(),
		.OutData(readBeat), .OutValid(readBeatValid), .OutReady(1'b1)
	);

	widthFunnel #(.InWidth(`ORAM_BED_WIDTH), .OutWidth(`ORAM_NET_WIDTH), .Registered(1'b1))
		writeFunnel (
		.Clock(Clock), .rstN(rstN),
		.InData(beatOut), .InValid(beatOutValid && !DummyMode), .InAccept(writeAccept),
		.OutData(DramWriteData), .OutValid(DramWriteDataValid),
		.OutReady(DramWriteDataReady)
	);

	// --------------------------------------------------
	// Status and debug readout
	// --------------------------------------------------
	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN)
			accessCount <= '0;
		else if (accessDone)
			accessCount <= accessCount + 1'b1;
	end

	assign statusWord = {accessCount, errorCount};

	// Request while empty captures, request while full shifts one byte
	widthFunnel #(.InWidth(`ORAM_STATUS_WIDTH), .OutWidth(`ORAM_DEBUG_WIDTH),
		.Registered(1'b0))
		debugFunnel (
		.Clock(Clock), .rstN(rstN),
		.InData(statusWord), .InValid(!debugFull && DebugReq), .InAccept(),
		.OutData(DebugData), .OutValid(debugFull), .OutReady(debugFull && DebugReq)
	);

endmodule

`default_nettype wire

/* src/dummyResponder.sv */
// Stand-in DRAM for dummy mode, read commands only
// First beat two cycles after the command, then one xorshift beat per cycle
`timescale 1ns/1ps
`default_nettype none

module dummyResponder (
	input wire logic Clock,
	input wire logic rstN,
	input wire logic CmdValid,
	output logic CmdReady,
	output oramTestPkg::beatData_t BeatOut,
	output logic BeatOutValid
);
	// 0 idle, 1 wait, 2 to 5 one beat each
	logic [2:0] phase;
	oramTestPkg::beatData_t lfsr;
	oramTestPkg::beatData_t stepA;
	oramTestPkg::beatData_t stepB;
	oramTestPkg::beatData_t lfsrNext;

	// xorshift32, shifts 13, 17, 5
	always_comb begin
		stepA = lfsr ^ (lfsr << 13);
		stepB = stepA ^ (stepA >> 17);
		lfsrNext = stepB ^ (stepB << 5);
	end

	assign CmdReady = phase == 3'd0;
	assign BeatOutValid = phase >= 3'd2;
	assign BeatOut = lfsr;

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			phase <= 3'd0;
			lfsr <= 32'h0000_0001;
		end else begin
			if (CmdValid && CmdReady)
				phase <= 3'd1;
			else if (phase != 3'd0)
				phase <= (phase == 3'd5) ? 3'd0 : phase + 3'd1;
			if (BeatOutValid)
				lfsr <= lfsrNext;
		end
	end

endmodule

`default_nettype wire

/* src/trafficGen.sv */
// Self-checking traffic source, write then read back of blocks 0, 1, 2 and so on
// Beat pattern is the block address over the beat index, error count saturates
`timescale 1ns/1ps
`default_nettype none
`include "oramTest_defs.svh"

module trafficGen (
	input wire logic Clock,
	input wire logic rstN,
	output oramTestPkg::frontCmd_t Cmd,
	output logic CmdValid,
	input wire logic CmdReady,
	output oramTestPkg::beatData_t DataIn,
	output logic DataInValid,
	input wire logic DataInReady,
	input wire oramTestPkg::beatData_t DataOut,
	input wire logic DataOutValid,
	output logic DataOutReady,
	output logic [`ORAM_STATUS_WIDTH/2-1:0] ErrorCount
);
	localparam int IdxWidth = $clog2(`ORAM_BLOCK_BEATS);
	localparam int LowWidth = `ORAM_BED_WIDTH - `ORAM_ADDR_WIDTH;
	localparam logic [IdxWidth-1:0] LastBeat = IdxWidth'(`ORAM_BLOCK_BEATS - 1);

	oramTestPkg::blockAddr_t addr;
	oramTestPkg::beatData_t pattern;
	logic [IdxWidth-1:0] beatIdx;
	logic writePhase;
	logic cmdSent;
	logic beatFire;
	logic readFire;

	// Expected or written beat
	assign pattern = {addr, LowWidth'(beatIdx)};

	always_comb begin
		Cmd.op = writePhase ? oramTestPkg::FrontWrite : oramTestPkg::FrontRead;
		Cmd.addr = addr;
		Cmd.mask = '1;
	end

	// Command first, then its four beats in one direction
	assign CmdValid = !cmdSent;
	assign DataIn = pattern;
	assign DataInValid = cmdSent && writePhase;
	assign DataOutReady = cmdSent && !writePhase;

	assign readFire = DataOutValid && DataOutReady;
	assign beatFire = (DataInValid && DataInReady) || readFire;

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			addr <= '0;
			beatIdx <= '0;
			writePhase <= 1'b1;
			cmdSent <= 1'b0;
			ErrorCount <= '0;
		end else begin
			if (CmdValid && CmdReady)
				cmdSent <= 1'b1;
			if (beatFire) begin
				beatIdx <= beatIdx + 1'b1;
				if (beatIdx == LastBeat) begin
					cmdSent <= 1'b0;
					writePhase <= !writePhase;
					// Next block once the read-back is done
					if (!writePhase)
						addr <= addr + 1'b1;
				end
			end
			if (readFire && (DataOut != pattern) && (ErrorCount != '1))
				ErrorCount <= ErrorCount + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* src/blockController.sv */
// Block access FSM, four backend beats per block, writes as read-merge-write
// Merge happens while the old block is collected, under the latched beat mask
// DummyMode loops read and write-back on incrementing addresses
`timescale 1ns/1ps
`default_nettype none
`include "oramTest_defs.svh"

module blockController (
	input wire logic Clock,
	input wire logic rstN,
	input wire logic DummyMode,
	input wire oramTestPkg::frontCmd_t Cmd,
	input wire logic CmdValid,
	output logic CmdReady,
	input wire oramTestPkg::beatData_t DataIn,
	input wire logic DataInValid,
	output logic DataInReady,
	output oramTestPkg::beatData_t DataOut,
	output logic DataOutValid,
	input wire logic DataOutReady,
	output oramTestPkg::dramCmd_t DramCmd,
	output logic DramCmdValid,
	input wire logic DramCmdReady,
	input wire oramTestPkg::beatData_t BeatIn,
	input wire logic BeatInValid,
	output oramTestPkg::beatData_t BeatOut,
	output logic BeatOutValid,
	input wire logic BeatOutReady,
	output logic AccessDone
);
	localparam int IdxWidth = $clog2(`ORAM_BLOCK_BEATS);
	localparam logic [IdxWidth-1:0] LastBeat = IdxWidth'(`ORAM_BLOCK_BEATS - 1);

	oramTestPkg::ctrlState_t state;
	oramTestPkg::frontCmd_t cmdQ;
	oramTestPkg::blockAddr_t dummyAddr;
	oramTestPkg::beatData_t blockBuf [`ORAM_BLOCK_BEATS];
	logic [IdxWidth-1:0] beatIdx;
	logic isWrite;
	logic keepNew;
	logic lastBeat;
	logic cmdFire;
	logic startDummy;

	// --------------------------------------------------
	// Handshake outputs
	// --------------------------------------------------
	assign isWrite = cmdQ.op == oramTestPkg::FrontWrite;
	// New beat survives the collect only when its mask bit is set
	assign keepNew = isWrite && cmdQ.mask[beatIdx];
	assign lastBeat = beatIdx == LastBeat;

	assign CmdReady = (state == oramTestPkg::Idle) && !DummyMode;
	assign cmdFire = CmdValid && CmdReady;
	assign startDummy = (state == oramTestPkg::Idle) && DummyMode;

	assign DataInReady = state == oramTestPkg::Gather;
	assign DataOutValid = state == oramTestPkg::ReturnBlock;
	assign DataOut = blockBuf[beatIdx];
	assign BeatOutValid = state == oramTestPkg::SendBlock;
	assign BeatOut = blockBuf[beatIdx];

	assign DramCmdValid = (state == oramTestPkg::IssueRead) || (state == oramTestPkg::IssueWrite);
	always_comb begin
		DramCmd.op = (state == oramTestPkg::IssueWrite) ? oramTestPkg::DramWrite
			: oramTestPkg::DramRead;
		DramCmd.addr = cmdQ.addr;
	end

	// End of an access, last beat out to the user or to DRAM
	assign AccessDone = lastBeat &&
		(((state == oramTestPkg::ReturnBlock) && DataOutReady) ||
		((state == oramTestPkg::SendBlock) && BeatOutReady));

	// --------------------------------------------------
	// Command latch and block buffer
	// --------------------------------------------------
	always_ff @(posedge Clock) begin
		if (cmdFire) begin
			cmdQ <= Cmd;
		end else if (startDummy) begin
			// Empty mask, so the write-back is the block just read
			cmdQ.op <= oramTestPkg::FrontWrite;
			cmdQ.addr <= dummyAddr;
			cmdQ.mask <= '0;
		end
		if ((state == oramTestPkg::Gather) && DataInValid)
			blockBuf[beatIdx] <= DataIn;
		if ((state == oramTestPkg::Collect) && BeatInValid && !keepNew)
			blockBuf[beatIdx] <= BeatIn;
	end

	// --------------------------------------------------
	// FSM
	// --------------------------------------------------
	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			state <= oramTestPkg::Idle;
			beatIdx <= '0;
			dummyAddr <= '0;
		end else begin
			case (state)
				oramTestPkg::Idle: begin
					if (startDummy) begin
						dummyAddr <= dummyAddr + 1'b1;
						state <= oramTestPkg::IssueRead;
					end else if (cmdFire) begin
						state <= (Cmd.op == oramTestPkg::FrontWrite) ? oramTestPkg::Gather
							: oramTestPkg::IssueRead;
					end
				end
				oramTestPkg::Gather: begin
					if (DataInValid) begin
						beatIdx <= beatIdx + 1'b1;
						if (lastBeat)
							state <= oramTestPkg::IssueRead;
					end
				end
				oramTestPkg::IssueRead: begin
					if (DramCmdReady)
						state <= oramTestPkg::Collect;
				end
				// Read data is never stalled, take it as it comes
				oramTestPkg::Collect: begin
					if (BeatInValid) begin
						beatIdx <= beatIdx + 1'b1;
						if (lastBeat)
							state <= isWrite ? oramTestPkg::IssueWrite
								: oramTestPkg::ReturnBlock;
					end
				end
				oramTestPkg::ReturnBlock: begin
					if (DataOutReady) begin
						beatIdx <= beatIdx + 1'b1;
						if (lastBeat)
							state <= oramTestPkg::Idle;
					end
				end
				oramTestPkg::IssueWrite: begin
					if (DramCmdReady)
						state <= oramTestPkg::SendBlock;
				end
				oramTestPkg::SendBlock: begin
					if (BeatOutReady) begin
						beatIdx <= beatIdx + 1'b1;
						if (lastBeat)
							state <= oramTestPkg::Idle;
					end
				end
				default: state <= oramTestPkg::Idle;
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/widthFunnel.sv */
// Width converter between two widths, one an integer multiple of the other
// Registered picks the unpack order: 1 sends low part first, 0 high part first
`timescale 1ns/1ps
`default_nettype none

module widthFunnel #(
	parameter int InWidth = 32,
	parameter int OutWidth = 64,
	parameter bit Registered = 1'b1
) (
	input wire logic Clock,
	input wire logic rstN,
	input wire logic [InWidth-1:0] InData,
	input wire logic InValid,
	output logic InAccept,
	output logic [OutWidth-1:0] OutData,
	output logic OutValid,
	input wire logic OutReady
);
	localparam int Wide = (InWidth > OutWidth) ? InWidth : OutWidth;
	localparam int Narrow = (InWidth > OutWidth) ? OutWidth : InWidth;
	localparam int Parts = Wide / Narrow;
	localparam int CountWidth = $clog2(Parts + 1);
	localparam logic [CountWidth-1:0] Full = CountWidth'(Parts);
	localparam logic [CountWidth-1:0] One = CountWidth'(1);

	// One wide word plus the number of parts it holds
	logic [Wide-1:0] buffer;
	logic [CountWidth-1:0] count;

	if (InWidth < OutWidth) begin : genPack
		// No new part while a full word waits
		assign InAccept = count != Full;
		assign OutValid = count == Full;
		assign OutData = buffer;

		always_ff @(posedge Clock or negedge rstN) begin
			if (!rstN) begin
				buffer <= '0;
				count <= '0;
			end else if (OutValid && OutReady) begin
				count <= '0;
			end else if (InValid && InAccept) begin
				// First part lands in the low bits
				buffer[count * Narrow +: Narrow] <= InData;
				count <= count + One;
			end
		end
	end else begin : genUnpack
		// Reload allowed as the last part leaves, so back-to-back words pass
		assign InAccept = (count == '0) || (count == One && OutReady);
		assign OutValid = count != '0;
		assign OutData = Registered ? buffer[Narrow-1:0] : buffer[Wide-1 -: Narrow];

		always_ff @(posedge Clock or negedge rstN) begin
			if (!rstN) begin
				buffer <= '0;
				count <= '0;
			end else if (InValid && InAccept) begin
				buffer <= InData;
				count <= Full;
			end else if (OutValid && OutReady) begin
				// Zeros shift in behind the sent part
				buffer <= Registered ? (buffer >> Narrow) : (buffer << Narrow);
				count <= count - One;
			end
		end
	end

endmodule

`default_nettype wire

/* src/oramTestPkg.sv */
// Types for the block-storage test wrapper
// Vector widths come from the macros in oramTest_defs.svh
`default_nettype none
`include "oramTest_defs.svh"

package oramTestPkg;

	// --------------------------------------------------
	// Data and address vectors
	// --------------------------------------------------
	typedef logic [`ORAM_BED_WIDTH-1:0] beatData_t;
	typedef logic [`ORAM_NET_WIDTH-1:0] netData_t;
	typedef logic [`ORAM_ADDR_WIDTH-1:0] blockAddr_t;
	typedef logic [`ORAM_BLOCK_BEATS-1:0] beatMask_t;
	typedef logic [`ORAM_DEBUG_WIDTH-1:0] debugByte_t;

	// --------------------------------------------------
	// Commands
	// --------------------------------------------------
	// Two-bit front op, upper codes spare
	typedef enum logic [1:0] {
		FrontRead = 2'd0,
		FrontWrite = 2'd1
	} frontOp_t;

	typedef enum logic {
		DramRead = 1'b0,
		DramWrite = 1'b1
	} dramOp_t;

	// Mask bit i enables beat i of a write
	typedef struct packed {
		frontOp_t op;
		blockAddr_t addr;
		beatMask_t mask;
	} frontCmd_t;

	typedef struct packed {
		dramOp_t op;
		blockAddr_t addr;
	} dramCmd_t;

	// Controller FSM
	typedef enum logic [2:0] {
		Idle,
		Gather,
		IssueRead,
		Collect,
		ReturnBlock,
		IssueWrite,
		SendBlock
	} ctrlState_t;

endpackage

`default_nettype wire

/* src/oramTest_defs.svh */
// Widths shared by the package, the RTL and the testbench
// Block geometry assumes ORAM_BLOCK_BEATS is a power of two
`ifndef ORAM_TEST_DEFS_SVH
`define ORAM_TEST_DEFS_SVH

// Backend beat, one 32-bit word of a block
`define ORAM_BED_WIDTH 32

// Network-side DRAM word
`define ORAM_NET_WIDTH 64

// Beats per block, so 128-bit blocks
`define ORAM_BLOCK_BEATS 4

// Block address width
`define ORAM_ADDR_WIDTH 16

// Debug port byte and the status word it shifts out
`define ORAM_DEBUG_WIDTH 8
`define ORAM_STATUS_WIDTH 32

`endif
